// ==== verilog/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    // Datapath and register file geometry.
    localparam int WORD_W    = 32;
    localparam int NUM_REGS  = 8;
    localparam int REG_IDX_W = 3;

    // One instruction is an opcode byte and two little-endian operands.
    localparam int INSTR_BYTES = 9;
    localparam int OPND_BYTES  = 4;

    // Opcode byte values.
    localparam logic [7:0] OP_NOP   = 8'h00;
    localparam logic [7:0] OP_MOVI  = 8'h01;
    localparam logic [7:0] OP_MOV   = 8'h02;
    localparam logic [7:0] OP_ADD   = 8'h03;
    localparam logic [7:0] OP_SUB   = 8'h04;
    localparam logic [7:0] OP_JMP   = 8'h05;
    localparam logic [7:0] OP_SETIV = 8'h06;
    localparam logic [7:0] OP_PUTC  = 8'h07;
    localparam logic [7:0] OP_IRET  = 8'h08;

    // Character cell index width of the text port.
    localparam int CELL_W = 11;

    // The interrupt value lands in R7.
    localparam logic [REG_IDX_W-1:0] KEY_REG = 3'd7;

    // An operand word is either an immediate or a register reference,
    // depending on the opcode that carries it.
    typedef union packed {
        logic [WORD_W-1:0] imm;
        struct packed {
            logic [WORD_W-REG_IDX_W-1:0] unused;
            logic [REG_IDX_W-1:0]        idx;
        } rf;
    } operand_u;

endpackage

// ==== verilog/cpu_irq_pkg.sv ====
package cpu_irq_pkg;

    // Vector table size and the matching type width.
    localparam int NUM_IRQ_TYPES = 4;
    localparam int IRQ_TYPE_W    = 2;

    // Interrupt type raised by the key input.
    localparam logic [IRQ_TYPE_W-1:0] IRQ_KEY = 2'd0;

    // Width of a key code carried as the interrupt value.
    localparam int KEY_W = 8;

    // Default number of queued interrupts.
    localparam int IRQ_QUEUE_DEPTH = 8;

endpackage

// ==== verilog/instr_fetch.sv ====
`timescale 1ns/1ps

module instr_fetch (
    input  logic                          CLOCK_50,
    input  logic                          rst_n_i,
    input  logic                          fetch_start_i,
    input  logic [cpu_isa_pkg::WORD_W-1:0] fetch_ip_i,
    output logic                          mem_req_o,
    output logic [cpu_isa_pkg::WORD_W-1:0] mem_addr_o,
    input  logic                          mem_ack_i,
    input  logic [7:0]                    mem_data_i,
    output logic                          instr_valid_o,
    output logic [7:0]                    opcode_o,
    output cpu_isa_pkg::operand_u         operand1_o,
    output cpu_isa_pkg::operand_u         operand2_o
);
    import cpu_isa_pkg::*;

    localparam int CNT_W = $clog2(INSTR_BYTES);

    localparam logic [1:0] S_IDLE     = 2'd0;
    localparam logic [1:0] S_ISSUE    = 2'd1;
    localparam logic [1:0] S_WAIT_ACK = 2'd2;
    localparam logic [1:0] S_WAIT_LOW = 2'd3;

    logic [1:0]       state;
    logic [CNT_W-1:0] byte_cnt;

    // Handshake control and byte counter.
    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            state         <= S_IDLE;
            byte_cnt      <= '0;
            mem_req_o     <= 1'b0;
            instr_valid_o <= 1'b0;
        end
        else
        begin
            instr_valid_o <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (fetch_start_i)
                    begin
                        byte_cnt <= '0;
                        state    <= S_ISSUE;
                    end
                end
                S_ISSUE:
                begin
                    // Only raise a request once the previous ack is gone.
                    if (!mem_ack_i)
                    begin
                        mem_req_o <= 1'b1;
                        state     <= S_WAIT_ACK;
                    end
                end
                S_WAIT_ACK:
                begin
                    if (mem_ack_i)
                    begin
                        mem_req_o <= 1'b0;
                        state     <= S_WAIT_LOW;
                    end
                end
                default:
                begin
                    if (!mem_ack_i)
                    begin
                        if (byte_cnt == CNT_W'(INSTR_BYTES - 1))
                        begin
                            instr_valid_o <= 1'b1;
                            state         <= S_IDLE;
                        end
                        else
                        begin
                            byte_cnt  <= byte_cnt + 1'b1;
                            mem_req_o <= 1'b1;
                            state     <= S_WAIT_ACK;
                        end
                    end
                end
            endcase
        end
    end

    // Address and instruction bytes.
    always_ff @(posedge CLOCK_50)
    begin
        if (state == S_IDLE && fetch_start_i)
        begin
            mem_addr_o <= fetch_ip_i;
        end
        else if (state == S_WAIT_LOW && !mem_ack_i)
        begin
            mem_addr_o <= mem_addr_o + 1'b1;
        end

        if (state == S_WAIT_ACK && mem_ack_i)
        begin
            // Operands arrive low byte first.
            if (byte_cnt == '0)
                opcode_o <= mem_data_i;
            else if (byte_cnt <= CNT_W'(OPND_BYTES))
                operand1_o.imm <= {mem_data_i, operand1_o.imm[WORD_W-1:8]};
            else
                operand2_o.imm <= {mem_data_i, operand2_o.imm[WORD_W-1:8]};
        end
    end

    a_addr_stable: assert property (
        @(posedge CLOCK_50) disable iff (!rst_n_i)
        (mem_req_o && $past(mem_req_o)) |-> $stable(mem_addr_o)
    );

endmodule

// ==== verilog/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic                               CLOCK_50,
    input  logic                               rst_n_i,
    output logic                               fetch_start_o,
    output logic [cpu_isa_pkg::WORD_W-1:0]     fetch_ip_o,
    input  logic                               instr_valid_i,
    input  logic [7:0]                         opcode_i,
    input  cpu_isa_pkg::operand_u              operand1_i,
    input  cpu_isa_pkg::operand_u              operand2_i,
    output logic                               vec_we_o,
    output logic [cpu_irq_pkg::IRQ_TYPE_W-1:0] vec_idx_o,
    output logic [cpu_isa_pkg::WORD_W-1:0]     vec_data_o,
    input  logic [cpu_isa_pkg::WORD_W-1:0]     vec_addr_i,
    input  logic                               irq_pending_i,
    input  logic [cpu_irq_pkg::IRQ_TYPE_W-1:0] irq_type_i,
    input  logic [cpu_irq_pkg::KEY_W-1:0]      irq_value_i,
    output logic                               irq_pop_o,
    output logic                               char_we_o,
    output logic [cpu_isa_pkg::CELL_W-1:0]     char_cell_o,
    output logic [7:0]                         char_data_o,
    output logic                               irq_active_o
);
    import cpu_isa_pkg::*;
    import cpu_irq_pkg::*;

    localparam logic [2:0] S_BOOT  = 3'd0;
    localparam logic [2:0] S_FETCH = 3'd1;
    localparam logic [2:0] S_WAIT  = 3'd2;
    localparam logic [2:0] S_EXEC  = 3'd3;
    localparam logic [2:0] S_CHECK = 3'd4;

    logic [2:0]           state;
    logic [WORD_W-1:0]    ip;
    logic                 ir;
    logic [WORD_W-1:0]    regs [NUM_REGS];
    logic [WORD_W-1:0]    shadow_regs [NUM_REGS];
    logic [WORD_W-1:0]    shadow_ip;
    logic [REG_IDX_W-1:0] dst_idx;
    logic [REG_IDX_W-1:0] src_idx;
    logic [WORD_W-1:0]    dst_val;
    logic [WORD_W-1:0]    src_val;
    logic                 take_irq;

    assign dst_idx = operand1_i.rf.idx;
    assign src_idx = operand2_i.rf.idx;
    assign dst_val = regs[dst_idx];
    assign src_val = regs[src_idx];

    assign take_irq = (state == S_CHECK) && irq_pending_i && !ir;

    assign fetch_start_o = (state == S_FETCH);
    assign fetch_ip_o    = ip;
    assign irq_pop_o     = take_irq;
    assign irq_active_o  = ir;

    // SETIV writes the table; in the check cycle the index selects the pending type.
    assign vec_we_o   = (state == S_EXEC) && (opcode_i == OP_SETIV);
    assign vec_idx_o  = (state == S_CHECK) ? irq_type_i : operand1_i.imm[IRQ_TYPE_W-1:0];
    assign vec_data_o = operand2_i.imm;

    assign char_we_o   = (state == S_EXEC) && (opcode_i == OP_PUTC);
    assign char_cell_o = operand1_i.imm[CELL_W-1:0];
    assign char_data_o = src_val[7:0];

    // Sequencer, register file and interrupt entry/return.
    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            state <= S_BOOT;
            ip    <= '0;
            ir    <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else
        begin
            case (state)
                S_BOOT:
                    state <= S_FETCH;
                S_FETCH:
                    state <= S_WAIT;
                S_WAIT:
                begin
                    if (instr_valid_i)
                        state <= S_EXEC;
                end
                S_EXEC:
                begin
                    state <= S_CHECK;
                    if (opcode_i != OP_JMP && opcode_i != OP_IRET)
                        ip <= ip + WORD_W'(INSTR_BYTES);
                    case (opcode_i)
                        OP_MOVI: regs[dst_idx] <= operand2_i.imm;
                        OP_MOV:  regs[dst_idx] <= src_val;
                        OP_ADD:  regs[dst_idx] <= dst_val + src_val;
                        OP_SUB:  regs[dst_idx] <= dst_val - src_val;
                        OP_JMP:  ip <= operand1_i.imm;
                        OP_IRET:
                        begin
                            for (int i = 0; i < NUM_REGS; i++)
                                regs[i] <= shadow_regs[i];
                            ip <= shadow_ip;
                            ir <= 1'b0;
                        end
                        default: ;
                    endcase
                end
                default:
                begin
                    state <= S_FETCH;
                    if (take_irq)
                    begin
                        // IP already points past the interrupted instruction.
                        regs[KEY_REG] <= {{(WORD_W-KEY_W){1'b0}}, irq_value_i};
                        ip <= vec_addr_i;
                        ir <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Saved copy of the main program state.
    always_ff @(posedge CLOCK_50)
    begin
        if (take_irq)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                shadow_regs[i] <= regs[i];
            shadow_ip <= ip;
        end
    end

    // A fetched instruction only arrives while the sequencer waits for it.
    a_valid_in_wait: assert property (
        @(posedge CLOCK_50) disable iff (!rst_n_i)
        instr_valid_i |-> state == S_WAIT
    );

endmodule

// ==== verilog/irq_vector_table.sv ====
`timescale 1ns/1ps

module irq_vector_table (
    input  logic                               CLOCK_50,
    input  logic                               rst_n_i,
    input  logic                               vec_we_i,
    input  logic [cpu_irq_pkg::IRQ_TYPE_W-1:0] vec_idx_i,
    input  logic [cpu_isa_pkg::WORD_W-1:0]     vec_data_i,
    output logic [cpu_isa_pkg::WORD_W-1:0]     vec_addr_o
);
    import cpu_isa_pkg::*;
    import cpu_irq_pkg::*;

    // One service routine address per interrupt type.
    logic [WORD_W-1:0] vec_table [NUM_IRQ_TYPES];

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < NUM_IRQ_TYPES; i++)
                vec_table[i] <= '0;
        end
        else if (vec_we_i)
        begin
            vec_table[vec_idx_i] <= vec_data_i;
        end
    end

    // The execute unit needs the address in the same cycle it takes the interrupt.
    assign vec_addr_o = vec_table[vec_idx_i];

endmodule

// ==== verilog/irq_queue.sv ====
`timescale 1ns/1ps

module irq_queue #(
    parameter int DEPTH = cpu_irq_pkg::IRQ_QUEUE_DEPTH
) (
    input  logic                               CLOCK_50,
    input  logic                               rst_n_i,
    input  logic                               key_valid_i,
    input  logic [cpu_irq_pkg::KEY_W-1:0]      key_code_i,
    input  logic                               irq_pop_i,
    output logic                               irq_pending_o,
    output logic [cpu_irq_pkg::IRQ_TYPE_W-1:0] irq_type_o,
    output logic [cpu_irq_pkg::KEY_W-1:0]      irq_value_o
);
    import cpu_irq_pkg::*;

    localparam int PTR_W   = $clog2(DEPTH);
    localparam int ENTRY_W = IRQ_TYPE_W + KEY_W;

    // Each entry keeps the type and its value together.
    logic [ENTRY_W-1:0] entries [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               full;
    logic               push;
    logic               pop;

    assign full = (count == (PTR_W+1)'(DEPTH));
    assign push = key_valid_i && !full;
    assign pop  = irq_pop_i && irq_pending_o;

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (push)
            entries[wr_ptr] <= {IRQ_KEY, key_code_i};
    end

    // The head of the queue is always on the outputs.
    assign irq_pending_o = (count != '0);
    assign {irq_type_o, irq_value_o} = entries[rd_ptr];

    a_count_bound: assert property (
        @(posedge CLOCK_50) disable iff (!rst_n_i)
        count <= (PTR_W+1)'(DEPTH)
    );

    // A pop must find a real entry at the head.
    a_pop_pending: assert property (
        @(posedge CLOCK_50) disable iff (!rst_n_i)
        irq_pop_i |-> irq_pending_o
    );

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                           CLOCK_50,
    input  logic                           rst_n_i,
    output logic                           mem_req_o,
    output logic [cpu_isa_pkg::WORD_W-1:0] mem_addr_o,
    input  logic                           mem_ack_i,
    input  logic [7:0]                     mem_data_i,
    input  logic                           key_valid_i,
    input  logic [cpu_irq_pkg::KEY_W-1:0]  key_code_i,
    output logic                           char_we_o,
    output logic [cpu_isa_pkg::CELL_W-1:0] char_cell_o,
    output logic [7:0]                     char_data_o,
    output logic                           irq_active_o
);
    import cpu_isa_pkg::*;
    import cpu_irq_pkg::*;

    logic                  fetch_start;
    logic [WORD_W-1:0]     fetch_ip;
    logic                  instr_valid;
    logic [7:0]            opcode;
    operand_u              operand1;
    operand_u              operand2;
    logic                  vec_we;
    logic [IRQ_TYPE_W-1:0] vec_idx;
    logic [WORD_W-1:0]     vec_data;
    logic [WORD_W-1:0]     vec_addr;
    logic                  irq_pending;
    logic [IRQ_TYPE_W-1:0] irq_type;
    logic [KEY_W-1:0]      irq_value;
    logic                  irq_pop;

    instr_fetch instr_fetch_inst (
        .CLOCK_50      (CLOCK_50),
        .rst_n_i       (rst_n_i),
        .fetch_start_i (fetch_start),
        .fetch_ip_i    (fetch_ip),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_ack_i     (mem_ack_i),
        .mem_data_i    (mem_data_i),
        .instr_valid_o (instr_valid),
        .opcode_o      (opcode),
        .operand1_o    (operand1),
        .operand2_o    (operand2)
    );

    execute_unit execute_unit_inst (
        .CLOCK_50      (CLOCK_50),
        .rst_n_i       (rst_n_i),
        .fetch_start_o (fetch_start),
        .fetch_ip_o    (fetch_ip),
        .instr_valid_i (instr_valid),
        .opcode_i      (opcode),
        .operand1_i    (operand1),
        .operand2_i    (operand2),
        .vec_we_o      (vec_we),
        .vec_idx_o     (vec_idx),
        .vec_data_o    (vec_data),
        .vec_addr_i    (vec_addr),
        .irq_pending_i (irq_pending),
        .irq_type_i    (irq_type),
        .irq_value_i   (irq_value),
        .irq_pop_o     (irq_pop),
        .char_we_o     (char_we_o),
        .char_cell_o   (char_cell_o),
        .char_data_o   (char_data_o),
        .irq_active_o  (irq_active_o)
    );

    irq_vector_table irq_vector_table_inst (
        .CLOCK_50   (CLOCK_50),
        .rst_n_i    (rst_n_i),
        .vec_we_i   (vec_we),
        .vec_idx_i  (vec_idx),
        .vec_data_i (vec_data),
        .vec_addr_o (vec_addr)
    );

    irq_queue #(
        .DEPTH (IRQ_QUEUE_DEPTH)
    ) irq_queue_inst (
        .CLOCK_50      (CLOCK_50),
        .rst_n_i       (rst_n_i),
        .key_valid_i   (key_valid_i),
        .key_code_i    (key_code_i),
        .irq_pop_i     (irq_pop),
        .irq_pending_o (irq_pending),
        .irq_type_o    (irq_type),
        .irq_value_o   (irq_value)
    );

endmodule

// ==== test/byte_mem_model.sv ====
`timescale 1ns/1ps

module byte_mem_model #(
    parameter int MEM_BYTES = 256
) (
    input  logic        CLOCK_50,
    input  logic        rst_n_i,
    input  logic        mem_req_i,
    input  logic [31:0] mem_addr_i,
    output logic        mem_ack_o,
    output logic [7:0]  mem_data_o
);
    logic [7:0] mem [MEM_BYTES];
    integer     seed = 32'h1943_7ad0;
    int         rnd_delay;
    logic       ack_q = 1'b0;
    logic [7:0] data_q = 8'h00;
    logic       waiting = 1'b0;
    logic [1:0] delay_cnt = 2'd0;

    assign mem_ack_o  = ack_q;
    assign mem_data_o = data_q;

    // Folds every address bit into the byte.
    function automatic logic [7:0] fill_pattern(input logic [31:0] addr);
        return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h5c;
    endfunction

    function automatic logic [7:0] read_byte(input logic [31:0] addr);
        if (addr < MEM_BYTES)
            return mem[addr];
        return fill_pattern(addr);
    endfunction

    task automatic fill_all();
        for (int a = 0; a < MEM_BYTES; a++)
            mem[a] = fill_pattern(32'(a));
    endtask

    task automatic write_byte(input logic [31:0] addr, input logic [7:0] data);
        mem[addr] = data;
    endtask

    // Four-phase responder with a random 0 to 3 cycle ack delay.
    always @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            ack_q   <= 1'b0;
            waiting <= 1'b0;
        end
        else if (ack_q)
        begin
            if (!mem_req_i)
                ack_q <= 1'b0;
        end
        else if (waiting)
        begin
            if (delay_cnt == 2'd0)
            begin
                ack_q   <= 1'b1;
                data_q  <= read_byte(mem_addr_i);
                waiting <= 1'b0;
            end
            else
            begin
                delay_cnt <= delay_cnt - 1'b1;
            end
        end
        else if (mem_req_i)
        begin
            rnd_delay = {$random(seed)} % 4;
            if (rnd_delay == 0)
            begin
                ack_q  <= 1'b1;
                data_q <= read_byte(mem_addr_i);
            end
            else
            begin
                waiting   <= 1'b1;
                delay_cnt <= 2'(rnd_delay - 1);
            end
        end
    end

endmodule

// ==== test/cpu_top_tb.sv ====
`timescale 1ns/1ps

module cpu_top_tb;
    import cpu_isa_pkg::*;
    import cpu_irq_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_KEYS     = 3;
    localparam int NUM_WRITES   = 6;
    localparam int MAIN_WRITES  = 3;
    localparam int IMM_A        = 5;
    localparam int IMM_B        = 3;
    localparam logic [WORD_W-1:0] JMP_ADDR = 32'(9 * INSTR_BYTES);
    localparam logic [WORD_W-1:0] ISR_ADDR = 32'(10 * INSTR_BYTES);
    // Main program, then per key a JMP in flight, PUTC and IRET, then the final JMP.
    localparam int RUN_INSTRS = 10 + 3 * NUM_KEYS + 1;

    logic              CLOCK_50 = 1'b0;
    logic              rst_n_i;
    logic              mem_req_o;
    logic [WORD_W-1:0] mem_addr_o;
    logic              mem_ack_i;
    logic [7:0]        mem_data_i;
    logic              key_valid_i;
    logic [KEY_W-1:0]  key_code_i;
    logic              char_we_o;
    logic [CELL_W-1:0] char_cell_o;
    logic [7:0]        char_data_o;
    logic              irq_active_o;

    logic [KEY_W-1:0]  key_code_tab [NUM_KEYS];
    int                key_gap_tab [NUM_KEYS];
    logic [CELL_W-1:0] exp_cell_tab [NUM_WRITES];
    logic [7:0]        exp_data_tab [NUM_WRITES];

    int                exp_idx = 0;
    int                irq_entries = 0;
    int                cycle_count = 0;
    int                timeout_limit = 0;
    int                value_errors = 0;
    int                protocol_errors = 0;
    int                missing_writes = 0;
    int                extra_writes = 0;
    int                timeouts = 0;
    logic              prev_req = 1'b0;
    logic [WORD_W-1:0] prev_addr = '0;
    logic              prev_irq_active = 1'b0;
    logic              first_req_seen = 1'b0;

    cpu_top cpu_top_inst (
        .CLOCK_50     (CLOCK_50),
        .rst_n_i      (rst_n_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_ack_i    (mem_ack_i),
        .mem_data_i   (mem_data_i),
        .key_valid_i  (key_valid_i),
        .key_code_i   (key_code_i),
        .char_we_o    (char_we_o),
        .char_cell_o  (char_cell_o),
        .char_data_o  (char_data_o),
        .irq_active_o (irq_active_o)
    );

    byte_mem_model byte_mem_model_inst (
        .CLOCK_50   (CLOCK_50),
        .rst_n_i    (rst_n_i),
        .mem_req_i  (mem_req_o),
        .mem_addr_i (mem_addr_o),
        .mem_ack_o  (mem_ack_i),
        .mem_data_o (mem_data_i)
    );

    initial
    begin
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    task automatic build_tables();
        int gap_sum;
        key_code_tab[0] = 8'h41;
        key_code_tab[1] = 8'h5a;
        key_code_tab[2] = 8'h33;
        // Idle cycles before each key; the last two keys arrive back to back.
        key_gap_tab[0] = 40;
        key_gap_tab[1] = 400;
        key_gap_tab[2] = 0;
        // ADD, then SUB, then MOV of the SUB result.
        exp_cell_tab[0] = 0;
        exp_data_tab[0] = 8'(IMM_A + IMM_B);
        exp_cell_tab[1] = 1;
        exp_data_tab[1] = 8'(IMM_A + IMM_B - IMM_B);
        exp_cell_tab[2] = 2;
        exp_data_tab[2] = 8'(IMM_A + IMM_B - IMM_B);
        for (int k = 0; k < NUM_KEYS; k++)
        begin
            exp_cell_tab[MAIN_WRITES + k] = 3;
            exp_data_tab[MAIN_WRITES + k] = key_code_tab[k];
        end
        gap_sum = 0;
        for (int k = 0; k < NUM_KEYS; k++)
            gap_sum += key_gap_tab[k] + 2;
        timeout_limit = RESET_CYCLES + 2 + RUN_INSTRS * INSTR_BYTES * 6 + gap_sum;
    endtask

    task automatic put_instr(input int slot, input logic [7:0] op,
                             input logic [31:0] opnd1, input logic [31:0] opnd2);
        logic [31:0] base;
        base = 32'(slot * INSTR_BYTES);
        byte_mem_model_inst.write_byte(base, op);
        for (int b = 0; b < OPND_BYTES; b++)
        begin
            byte_mem_model_inst.write_byte(base + 1 + b, opnd1[8*b +: 8]);
            byte_mem_model_inst.write_byte(base + 1 + OPND_BYTES + b, opnd2[8*b +: 8]);
        end
    endtask

    task automatic load_program();
        byte_mem_model_inst.fill_all();
        put_instr(0, OP_SETIV, 32'(IRQ_KEY), ISR_ADDR);
        put_instr(1, OP_MOVI, 1, IMM_A);
        put_instr(2, OP_MOVI, 2, IMM_B);
        put_instr(3, OP_ADD, 1, 2);
        put_instr(4, OP_PUTC, 0, 1);
        put_instr(5, OP_SUB, 1, 2);
        put_instr(6, OP_PUTC, 1, 1);
        put_instr(7, OP_MOV, 3, 1);
        put_instr(8, OP_PUTC, 2, 3);
        put_instr(9, OP_JMP, JMP_ADDR, 0);
        // Key service routine.
        put_instr(10, OP_PUTC, 3, 32'(KEY_REG));
        put_instr(11, OP_IRET, 0, 0);
    endtask

    task automatic finish_run();
        if (exp_idx < NUM_WRITES)
        begin
            missing_writes = NUM_WRITES - exp_idx;
            $display("Missing character writes: %0d of %0d never arrived",
                     missing_writes, NUM_WRITES);
        end
        $display("Errors: value %0d, protocol %0d, missing %0d, extra %0d, timeout %0d",
                 value_errors, protocol_errors, missing_writes, extra_writes, timeouts);
        if (value_errors + protocol_errors + missing_writes + extra_writes + timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    // Character writes against the expected table.
    always @(negedge CLOCK_50)
    begin
        if (rst_n_i && char_we_o)
        begin
            if (exp_idx >= NUM_WRITES)
            begin
                extra_writes++;
                $display("Unexpected extra character write at %0t: cell %0d data 0x%02h",
                         $time, char_cell_o, char_data_o);
            end
            else
            begin
                if (char_cell_o !== exp_cell_tab[exp_idx] ||
                    char_data_o !== exp_data_tab[exp_idx])
                begin
                    value_errors++;
                    $display("CHECK FAILED at %0t: write %0d expected %0d/%02h, got %0d/%02h",
                             $time, exp_idx, exp_cell_tab[exp_idx], exp_data_tab[exp_idx],
                             char_cell_o, char_data_o);
                end
                if (exp_idx >= MAIN_WRITES && irq_active_o !== 1'b1)
                begin
                    value_errors++;
                    $display("CHECK FAILED at %0t: key write %0d outside a service routine",
                             $time, exp_idx);
                end
                if (exp_idx < MAIN_WRITES && irq_active_o !== 1'b0)
                begin
                    value_errors++;
                    $display("CHECK FAILED at %0t: irq_active_o high in main program",
                             $time);
                end
                // Each routine must have its own entry, so the next waits for IRET.
                if (exp_idx >= MAIN_WRITES && irq_entries != exp_idx - MAIN_WRITES + 1)
                begin
                    value_errors++;
                    $display("CHECK FAILED at %0t: write %0d seen after %0d interrupt entries",
                             $time, exp_idx, irq_entries);
                end
                exp_idx++;
            end
        end
    end

    // Four-phase rule on the memory port and interrupt entry count.
    always @(negedge CLOCK_50)
    begin
        if (rst_n_i)
        begin
            if (mem_req_o && !prev_req && mem_ack_i)
            begin
                protocol_errors++;
                $display("Memory request raised at %0t while ack was still high", $time);
            end
            if (mem_req_o && prev_req && mem_addr_o !== prev_addr)
            begin
                protocol_errors++;
                $display("Memory address changed at %0t while req was high", $time);
            end
            if (mem_req_o && !first_req_seen)
            begin
                first_req_seen = 1'b1;
                if (mem_addr_o !== '0)
                begin
                    value_errors++;
                    $display("CHECK FAILED at %0t: first fetch address expected 0, got 0x%08h",
                             $time, mem_addr_o);
                end
            end
            if (irq_active_o && !prev_irq_active)
                irq_entries++;
        end
        prev_req        = mem_req_o;
        prev_addr       = mem_addr_o;
        prev_irq_active = irq_active_o;
    end

    always @(posedge CLOCK_50)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit)
        begin
            timeouts++;
            $display("Timeout after %0d cycles: the program did not complete", cycle_count);
            finish_run();
        end
    end

    initial
    begin
        rst_n_i     = 1'b0;
        key_valid_i = 1'b0;
        key_code_i  = '0;
        build_tables();
        load_program();
        repeat (RESET_CYCLES)
        begin
            @(negedge CLOCK_50);
            if (char_we_o !== 1'b0 || mem_req_o !== 1'b0)
            begin
                value_errors++;
                $display("CHECK FAILED at %0t: char_we_o or mem_req_o active in reset", $time);
            end
        end
        @(posedge CLOCK_50);
        rst_n_i <= 1'b1;

        while (exp_idx < MAIN_WRITES)
            @(negedge CLOCK_50);

        // Keys are injected while the core spins on its JMP.
        for (int k = 0; k < NUM_KEYS; k++)
        begin
            if (key_gap_tab[k] > 0)
            begin
                @(posedge CLOCK_50);
                key_valid_i <= 1'b0;
                repeat (key_gap_tab[k] - 1)
                    @(posedge CLOCK_50);
            end
            @(posedge CLOCK_50);
            key_valid_i <= 1'b1;
            key_code_i  <= key_code_tab[k];
        end
        @(posedge CLOCK_50);
        key_valid_i <= 1'b0;

        while (exp_idx < NUM_WRITES)
            @(negedge CLOCK_50);
        // Done once the last routine has returned to the JMP.
        while (!(mem_req_o && !irq_active_o && mem_addr_o == JMP_ADDR))
            @(negedge CLOCK_50);
        finish_run();
    end

endmodule

// ==== tb.f ====
verilog/cpu_isa_pkg.sv
verilog/cpu_irq_pkg.sv
verilog/instr_fetch.sv
verilog/execute_unit.sv
verilog/irq_vector_table.sv
verilog/irq_queue.sv
verilog/cpu_top.sv
test/byte_mem_model.sv
test/cpu_top_tb.sv
